//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --top-module rvCoreTb -f flist.f --Mdir obj_dir -o rvCoreSim
	./obj_dir/rvCoreSim | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
hdl/rvPkg.sv
hdl/fetchStage.sv
hdl/controlUnit.sv
hdl/regFile.sv
hdl/executeStage.sv
hdl/memStage.sv
hdl/rvCore.sv
verif/tbClock.sv
verif/rvCoreTb.sv

//--- hdl/controlUnit.sv
`timescale 1ns/1ps
module controlUnit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [rvPkg::xlen-1:0]   instrD,
    input  logic [rvPkg::xlen-1:0]   pcD,
    input  logic                     validD,
    input  logic [rvPkg::xlen-1:0]   rd1,
    input  logic [rvPkg::xlen-1:0]   rd2,
    input  rvPkg::exMemT             exMem,
    input  rvPkg::wbT                wbBus,
    input  logic                     wbWe,
    input  rvPkg::redirectT          redirect,
    output logic [rvPkg::regAw-1:0]  rs1,
    output logic [rvPkg::regAw-1:0]  rs2,
    output logic                     stallF,
    output logic                     flushD,
    output rvPkg::idExT              idEx,
    output rvPkg::fwdT               fwdA,
    output rvPkg::fwdT               fwdB
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [rvPkg::xlen-1:0] immI;
    logic [rvPkg::xlen-1:0] immS;
    logic [rvPkg::xlen-1:0] immB;
    logic [rvPkg::xlen-1:0] immJ;
    rvPkg::opT              opD;
    rvPkg::idExT            dec;
    logic                   loadUse;

    // pick the newest producer of rs, mem stage first
    function automatic rvPkg::fwdT fwdSel(input logic [rvPkg::regAw-1:0] rs);
        if (rs != '0 && exMem.valid && exMem.regWrite && !exMem.memRead && exMem.rd == rs) begin
            return rvPkg::fwdMem;
        end else if (rs != '0 && wbWe && wbBus.rd == rs) begin
            return rvPkg::fwdWb;
        end
        return rvPkg::fwdNone;
    endfunction

    assign opcode = instrD[6:0];
    assign funct3 = instrD[14:12];
    assign rs1 = instrD[19:15];
    assign rs2 = instrD[24:20];

    assign immI = {{20{instrD[31]}}, instrD[31:20]};
    assign immS = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
    assign immB = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};
    assign immJ = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20], instrD[30:21], 1'b0};

    always_comb begin
        opD = rvPkg::opNop;
        if (validD) begin
            case (opcode)
                7'b0110011: begin
                    case (funct3)
                        3'b000: opD = instrD[30] ? rvPkg::opSub : rvPkg::opAdd;
                        3'b111: opD = rvPkg::opAnd;
                        3'b110: opD = rvPkg::opOr;
                        3'b010: opD = rvPkg::opSlt;
                        default: opD = rvPkg::opNop;
                    endcase
                end
                7'b0010011: opD = (funct3 == 3'b000) ? rvPkg::opAddi : rvPkg::opNop;
                7'b0000011: opD = (funct3 == 3'b010) ? rvPkg::opLw : rvPkg::opNop;
                7'b0100011: opD = (funct3 == 3'b010) ? rvPkg::opSw : rvPkg::opNop;
                7'b1100011: opD = (funct3 == 3'b000) ? rvPkg::opBeq : rvPkg::opNop;
                7'b1101111: opD = rvPkg::opJal;
                default: opD = rvPkg::opNop;
            endcase
        end
    end

    always_comb begin
        dec = '0;
        dec.valid = validD;
        dec.op = opD;
        dec.alu = rvPkg::aluAdd;
        dec.result = rvPkg::resAlu;
        dec.pc = pcD;
        dec.pcPlus4 = pcD + 32'd4;
        dec.rs1 = rs1;
        dec.rs2 = rs2;
        dec.rd = instrD[11:7];
        dec.rd1 = rd1;
        dec.rd2 = rd2;
        case (opD)
            rvPkg::opAdd: dec.regWrite = 1'b1;
            rvPkg::opSub: begin
                dec.alu = rvPkg::aluSub;
                dec.regWrite = 1'b1;
            end
            rvPkg::opAnd: begin
                dec.alu = rvPkg::aluAnd;
                dec.regWrite = 1'b1;
            end
            rvPkg::opOr: begin
                dec.alu = rvPkg::aluOr;
                dec.regWrite = 1'b1;
            end
            rvPkg::opSlt: begin
                dec.alu = rvPkg::aluSlt;
                dec.regWrite = 1'b1;
            end
            rvPkg::opAddi: begin
                dec.imm = immI;
                dec.useImm = 1'b1;
                dec.regWrite = 1'b1;
            end
            rvPkg::opLw: begin
                dec.imm = immI;
                dec.useImm = 1'b1;
                dec.regWrite = 1'b1;
                dec.memRead = 1'b1;
                dec.result = rvPkg::resMem;
            end
            rvPkg::opSw: begin
                dec.imm = immS;
                dec.useImm = 1'b1;
                dec.memWrite = 1'b1;
            end
            rvPkg::opBeq: dec.imm = immB;
            rvPkg::opJal: begin
                dec.imm = immJ;
                dec.regWrite = 1'b1;
                dec.result = rvPkg::resPcPlus4;
            end
            default: dec.regWrite = 1'b0;
        endcase
    end

    // load in execute feeding the instruction in decode
    assign loadUse = validD && idEx.valid && idEx.memRead && idEx.rd != '0 &&
                     (idEx.rd == rs1 || idEx.rd == rs2);
    assign stallF = loadUse;
    assign flushD = redirect.taken;

    assign fwdA = fwdSel(idEx.rs1);
    assign fwdB = fwdSel(idEx.rs2);

    always_ff @(posedge clk) begin
        if (reset || loadUse || redirect.taken) begin
            idEx <= '0;
        end else begin
            idEx <= dec;
        end
    end

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ps
module executeStage (
    input  logic                     clk,
    input  logic                     reset,
    input  rvPkg::idExT              idEx,
    input  rvPkg::fwdT               fwdA,
    input  rvPkg::fwdT               fwdB,
    input  logic [rvPkg::xlen-1:0]   wbData,
    output rvPkg::exMemT             exMem,
    output rvPkg::redirectT          redirect
);

    logic [rvPkg::xlen-1:0] srcA;
    logic [rvPkg::xlen-1:0] fwdRs2;
    logic [rvPkg::xlen-1:0] srcB;
    logic [rvPkg::xlen-1:0] aluOut;
    rvPkg::exMemT           exNext;

    function automatic logic [rvPkg::xlen-1:0] fwdMux(
        input rvPkg::fwdT             sel,
        input logic [rvPkg::xlen-1:0] regVal
    );
        case (sel)
            rvPkg::fwdMem: return exMem.aluResult;
            rvPkg::fwdWb: return wbData;
            default: return regVal;
        endcase
    endfunction

    assign srcA = fwdMux(fwdA, idEx.rd1);
    assign fwdRs2 = fwdMux(fwdB, idEx.rd2);
    assign srcB = idEx.useImm ? idEx.imm : fwdRs2;

    always_comb begin
        case (idEx.alu)
            rvPkg::aluSub: aluOut = srcA - srcB;
            rvPkg::aluAnd: aluOut = srcA & srcB;
            rvPkg::aluOr: aluOut = srcA | srcB;
            rvPkg::aluSlt: aluOut = {{(rvPkg::xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default: aluOut = srcA + srcB;
        endcase
    end

    // beq compares the forwarded register values, not srcB
    always_comb begin
        redirect.taken = idEx.valid &&
                         ((idEx.op == rvPkg::opBeq && srcA == fwdRs2) ||
                          idEx.op == rvPkg::opJal);
        redirect.target = idEx.pc + idEx.imm;
    end

    always_comb begin
        exNext.valid = idEx.valid;
        exNext.aluResult = aluOut;
        exNext.writeData = fwdRs2;
        exNext.pcPlus4 = idEx.pcPlus4;
        exNext.rd = idEx.rd;
        exNext.regWrite = idEx.regWrite;
        exNext.memWrite = idEx.memWrite;
        exNext.memRead = idEx.memRead;
        exNext.result = idEx.result;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem.valid <= 1'b0;
            exMem.regWrite <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.memRead <= 1'b0;
        end else begin
            exMem <= exNext;
        end
    end

endmodule

//--- hdl/fetchStage.sv
`timescale 1ns/1ps
module fetchStage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     progWe,
    input  logic [rvPkg::imemAw-1:0] progAddr,
    input  logic [rvPkg::xlen-1:0]   progData,
    input  logic                     stallF,
    input  logic                     flushD,
    input  rvPkg::redirectT          redirect,
    output logic [rvPkg::xlen-1:0]   instrD,
    output logic [rvPkg::xlen-1:0]   pcD,
    output logic                     validD
);

    logic [rvPkg::xlen-1:0] imem [rvPkg::imemDepth];
    logic [rvPkg::xlen-1:0] pcF;

    // program port only open while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset && progWe) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= '0;
        end else if (redirect.taken) begin
            pcF <= redirect.target;
        end else if (!stallF) begin
            pcF <= pcF + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flushD) begin
            validD <= 1'b0;
        end else if (!stallF) begin
            validD <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallF) begin
            instrD <= imem[pcF[rvPkg::imemAw+1:2]];
            pcD <= pcF;
        end
    end

endmodule

//--- hdl/memStage.sv
`timescale 1ns/1ps
module memStage (
    input  logic                     clk,
    input  logic                     reset,
    input  rvPkg::exMemT             exMem,
    output rvPkg::wbT                wbBus,
    output logic                     wbWe,
    output rvPkg::storeT             store,
    output logic                     storeValid,
    output rvPkg::wbT                retire,
    output logic                     retireValid
);

    logic [rvPkg::xlen-1:0]   dmem [rvPkg::dmemDepth];
    logic [rvPkg::dmemAw-1:0] wordAddr;
    logic [rvPkg::xlen-1:0]   loadData;
    logic [rvPkg::xlen-1:0]   resultM;

    // word aligned, low two address bits dropped
    assign wordAddr = exMem.aluResult[rvPkg::dmemAw+1:2];
    assign loadData = dmem[wordAddr];

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.memWrite) begin
            dmem[wordAddr] <= exMem.writeData;
        end
    end

    always_comb begin
        case (exMem.result)
            rvPkg::resMem: resultM = loadData;
            rvPkg::resPcPlus4: resultM = exMem.pcPlus4;
            default: resultM = exMem.aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbWe <= 1'b0;
        end else begin
            wbWe <= exMem.valid && exMem.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbBus.rd <= exMem.rd;
        wbBus.data <= resultM;
    end

    assign store.addr = {2'b00, exMem.aluResult[rvPkg::xlen-1:2]};
    assign store.data = exMem.writeData;
    assign storeValid = exMem.valid && exMem.memWrite;

    assign retire = wbBus;
    assign retireValid = wbWe && wbBus.rd != '0;

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps
module regFile (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [rvPkg::regAw-1:0]  rs1,
    input  logic [rvPkg::regAw-1:0]  rs2,
    input  rvPkg::wbT                wbBus,
    input  logic                     wbWe,
    output logic [rvPkg::xlen-1:0]   rd1,
    output logic [rvPkg::xlen-1:0]   rd2
);

    logic [rvPkg::xlen-1:0] regs [rvPkg::regCount];

    // x0 reads zero, a write in flight wins over the array
    function automatic logic [rvPkg::xlen-1:0] readPort(input logic [rvPkg::regAw-1:0] rs);
        if (rs == '0) begin
            return '0;
        end else if (wbWe && wbBus.rd == rs) begin
            return wbBus.data;
        end
        return regs[rs];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rvPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWe && wbBus.rd != '0) begin
            regs[wbBus.rd] <= wbBus.data;
        end
    end

    assign rd1 = readPort(rs1);
    assign rd2 = readPort(rs2);

endmodule

//--- hdl/rvCore.sv
`timescale 1ns/1ps
module rvCore (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     progWe,
    input  logic [rvPkg::imemAw-1:0] progAddr,
    input  logic [rvPkg::xlen-1:0]   progData,
    output rvPkg::wbT                retire,
    output logic                     retireValid,
    output rvPkg::storeT             store,
    output logic                     storeValid
);

    logic [rvPkg::xlen-1:0]  instrD;
    logic [rvPkg::xlen-1:0]  pcD;
    logic                    validD;
    logic                    stallF;
    logic                    flushD;
    logic [rvPkg::regAw-1:0] rs1;
    logic [rvPkg::regAw-1:0] rs2;
    logic [rvPkg::xlen-1:0]  rd1;
    logic [rvPkg::xlen-1:0]  rd2;
    rvPkg::idExT             idEx;
    rvPkg::fwdT              fwdA;
    rvPkg::fwdT              fwdB;
    rvPkg::exMemT            exMem;
    rvPkg::redirectT         redirect;
    rvPkg::wbT               wbBus;
    logic                    wbWe;

    fetchStage fetch0 (
        .clk(clk), .reset(reset),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .stallF(stallF), .flushD(flushD), .redirect(redirect),
        .instrD(instrD), .pcD(pcD), .validD(validD)
    );

    controlUnit control0 (
        .clk(clk), .reset(reset),
        .instrD(instrD), .pcD(pcD), .validD(validD),
        .rd1(rd1), .rd2(rd2),
        .exMem(exMem), .wbBus(wbBus), .wbWe(wbWe), .redirect(redirect),
        .rs1(rs1), .rs2(rs2),
        .stallF(stallF), .flushD(flushD),
        .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB)
    );

    regFile regs0 (
        .clk(clk), .reset(reset),
        .rs1(rs1), .rs2(rs2),
        .wbBus(wbBus), .wbWe(wbWe),
        .rd1(rd1), .rd2(rd2)
    );

    executeStage execute0 (
        .clk(clk), .reset(reset),
        .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
        .wbData(wbBus.data),
        .exMem(exMem), .redirect(redirect)
    );

    memStage mem0 (
        .clk(clk), .reset(reset),
        .exMem(exMem),
        .wbBus(wbBus), .wbWe(wbWe),
        .store(store), .storeValid(storeValid),
        .retire(retire), .retireValid(retireValid)
    );

endmodule

//--- hdl/rvPkg.sv
package rvPkg;

    localparam int xlen = 32;
    localparam int regCount = 32;
    localparam int regAw = $clog2(regCount);
    localparam int imemDepth = 256;
    localparam int imemAw = $clog2(imemDepth);
    localparam int dmemDepth = 256;
    localparam int dmemAw = $clog2(dmemDepth);

    // decoded operations, opNop for anything unsupported
    typedef enum logic [3:0] {
        opNop, opAdd, opSub, opAnd, opOr, opSlt,
        opAddi, opLw, opSw, opBeq, opJal
    } opT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluT;

    typedef enum logic [1:0] {resAlu, resMem, resPcPlus4} resultT;

    typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdT;

    typedef struct packed {
        logic              valid;
        opT                op;
        aluT               alu;
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   pcPlus4;
        logic [regAw-1:0]  rs1;
        logic [regAw-1:0]  rs2;
        logic [regAw-1:0]  rd;
        logic [xlen-1:0]   imm;
        logic              regWrite;
        logic              memWrite;
        logic              memRead;
        logic              useImm;
        resultT            result;
        logic [xlen-1:0]   rd1;
        logic [xlen-1:0]   rd2;
    } idExT;

    typedef struct packed {
        logic              valid;
        logic [xlen-1:0]   aluResult;
        logic [xlen-1:0]   writeData;
        logic [xlen-1:0]   pcPlus4;
        logic [regAw-1:0]  rd;
        logic              regWrite;
        logic              memWrite;
        logic              memRead;
        resultT            result;
    } exMemT;

    typedef struct packed {
        logic [regAw-1:0]  rd;
        logic [xlen-1:0]   data;
    } wbT;

    // addr is a word address
    typedef struct packed {
        logic [xlen-1:0]   addr;
        logic [xlen-1:0]   data;
    } storeT;

    typedef struct packed {
        logic              taken;
        logic [xlen-1:0]   target;
    } redirectT;

endpackage

//--- verif/rvCoreTb.sv
`timescale 1ns/1ps
module rvCoreTb;

    localparam int clkPeriodNs = 8;
    localparam int resetCycles = 16;
    localparam int windowCycles = 100;
    localparam int testCount = 5;
    localparam int cyclesPerTest = 300;

    logic                     clk;
    logic                     reset;
    logic                     progWe;
    logic [rvPkg::imemAw-1:0] progAddr;
    logic [rvPkg::xlen-1:0]   progData;
    rvPkg::wbT                retire;
    logic                     retireValid;
    rvPkg::storeT             store;
    logic                     storeValid;

    integer       seed;
    int           testErrors;
    int           passCount;
    int           failCount;
    logic [31:0]  prog [$];
    rvPkg::wbT    expWb [$];
    rvPkg::wbT    gotWb [$];
    rvPkg::storeT expSt [$];
    rvPkg::storeT gotSt [$];

    tbClock clock0 (.clk(clk));

    rvCore dut0 (
        .clk(clk), .reset(reset),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .retire(retire), .retireValid(retireValid),
        .store(store), .storeValid(storeValid)
    );

    // instruction encoders, RV32I field layout
    function automatic logic [31:0] rType(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'h03};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] beq(input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic newTest();
        prog.delete();
        expWb.delete();
        expSt.delete();
        testErrors = 0;
    endtask

    task automatic expectRetire(input int rd, input logic [31:0] data);
        rvPkg::wbT w;
        w.rd = rd[4:0];
        w.data = data;
        expWb.push_back(w);
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        rvPkg::storeT s;
        s.addr = addr;
        s.data = data;
        expSt.push_back(s);
    endtask

    task automatic compareWb(input string name, input rvPkg::wbT expected,
                             input rvPkg::wbT actual);
        if (actual !== expected) begin
            $display("Error: %s expected rd=%h data=%h, got rd=%h data=%h",
                     name, expected.rd, expected.data, actual.rd, actual.data);
            testErrors++;
        end
    endtask

    task automatic compareStore(input string name, input rvPkg::storeT expected,
                                input rvPkg::storeT actual);
        if (actual !== expected) begin
            $display("Error: %s expected addr=%h data=%h, got addr=%h data=%h",
                     name, expected.addr, expected.data, actual.addr, actual.data);
            testErrors++;
        end
    endtask

    // load during reset, run a fixed window, then check both event queues
    task automatic runAndCheck(input string name);
        int loadCycles;
        loadCycles = (prog.size() > resetCycles) ? prog.size() : resetCycles;
        gotWb.delete();
        gotSt.delete();
        if (prog.size() > rvPkg::imemDepth) begin
            $display("%s: program does not fit in instruction memory", name);
            testErrors++;
        end
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < loadCycles; i++) begin
            progWe = (i < prog.size());
            progAddr = i[rvPkg::imemAw-1:0];
            progData = (i < prog.size()) ? prog[i] : 32'h0;
            @(negedge clk);
        end
        progWe = 1'b0;
        reset = 1'b0;
        repeat (windowCycles) begin
            @(negedge clk);
            if (retireValid) begin
                gotWb.push_back(retire);
            end
            if (storeValid) begin
                gotSt.push_back(store);
            end
        end
        for (int i = 0; i < expWb.size() && i < gotWb.size(); i++) begin
            compareWb($sformatf("retire[%0d]", i), expWb[i], gotWb[i]);
        end
        if (gotWb.size() != expWb.size()) begin
            $display("%s: expected %0d register writes to retire but saw %0d",
                     name, expWb.size(), gotWb.size());
            testErrors++;
        end
        for (int i = 0; i < expSt.size() && i < gotSt.size(); i++) begin
            compareStore($sformatf("store[%0d]", i), expSt[i], gotSt[i]);
        end
        if (gotSt.size() != expSt.size()) begin
            $display("%s: expected %0d stores but saw %0d", name, expSt.size(), gotSt.size());
            testErrors++;
        end
        if (testErrors == 0) begin
            $display("%s: passed", name);
            passCount++;
        end else begin
            $display("%s: failed with %0d errors", name, testErrors);
            failCount++;
        end
    endtask

    // back to back dependences, forwarded from mem and wb
    task automatic aluChainTest();
        int immA;
        int immB;
        logic [31:0] v [1:8];
        newTest();
        immA = $random(seed) % 2000;
        immB = $random(seed) % 2000;
        prog.push_back(addi(1, 0, immA));
        prog.push_back(addi(2, 0, immB));
        prog.push_back(rType('h00, 0, 3, 1, 2));
        prog.push_back(rType('h20, 0, 4, 3, 1));
        prog.push_back(rType('h00, 7, 5, 4, 3));
        prog.push_back(rType('h00, 6, 6, 5, 4));
        prog.push_back(rType('h00, 2, 7, 6, 5));
        prog.push_back(rType('h00, 2, 8, 5, 6));
        prog.push_back(jal(0, 0));
        v[1] = immA;
        v[2] = immB;
        v[3] = v[1] + v[2];
        v[4] = v[3] - v[1];
        v[5] = v[4] & v[3];
        v[6] = v[5] | v[4];
        v[7] = ($signed(v[6]) < $signed(v[5])) ? 32'd1 : 32'd0;
        v[8] = ($signed(v[5]) < $signed(v[6])) ? 32'd1 : 32'd0;
        for (int k = 1; k <= 8; k++) begin
            expectRetire(k, v[k]);
        end
        runAndCheck("alu chain");
    endtask

    task automatic zeroRegTest();
        int immA;
        int immB;
        newTest();
        immA = $random(seed) % 2000;
        immB = $random(seed) % 2000;
        prog.push_back(addi(0, 0, immA));
        prog.push_back(addi(1, 0, immB));
        prog.push_back(rType('h00, 0, 0, 1, 1));
        prog.push_back(rType('h00, 0, 2, 0, 1));
        prog.push_back(rType('h00, 0, 3, 0, 0));
        prog.push_back(jal(0, 0));
        expectRetire(1, immB);
        expectRetire(2, immB);
        expectRetire(3, 32'd0);
        runAndCheck("register zero");
    endtask

    task automatic loadUseTest();
        int immA;
        newTest();
        immA = $random(seed) % 2000;
        prog.push_back(addi(1, 0, immA));
        prog.push_back(addi(2, 0, 'h40));
        prog.push_back(sw(1, 2, 8));
        prog.push_back(lw(3, 2, 8));
        // consumer right behind the load
        prog.push_back(rType('h00, 0, 4, 3, 1));
        prog.push_back(sw(4, 2, 12));
        prog.push_back(jal(0, 0));
        expectRetire(1, immA);
        expectRetire(2, 32'h40);
        expectRetire(3, immA);
        expectRetire(4, immA + immA);
        expectStore(32'd18, immA);
        expectStore(32'd19, immA + immA);
        runAndCheck("load use");
    endtask

    task automatic branchTest();
        int immA;
        newTest();
        immA = $random(seed) % 2000;
        prog.push_back(addi(1, 0, immA));
        prog.push_back(addi(2, 0, immA));
        prog.push_back(addi(3, 0, immA + 1));
        prog.push_back(beq(1, 3, 8));
        prog.push_back(addi(4, 0, 1));
        // taken, lands on pc 32
        prog.push_back(beq(1, 2, 12));
        prog.push_back(addi(5, 0, 2));
        prog.push_back(addi(6, 0, 3));
        prog.push_back(addi(7, 0, 4));
        prog.push_back(jal(0, 0));
        expectRetire(1, immA);
        expectRetire(2, immA);
        expectRetire(3, immA + 1);
        expectRetire(4, 32'd1);
        expectRetire(7, 32'd4);
        runAndCheck("beq");
    endtask

    task automatic jalTest();
        int immA;
        newTest();
        immA = $random(seed) % 2000;
        prog.push_back(addi(1, 0, immA));
        prog.push_back(jal(5, 12));
        prog.push_back(addi(2, 0, 1));
        prog.push_back(addi(3, 0, 2));
        prog.push_back(rType('h00, 0, 4, 5, 1));
        prog.push_back(jal(6, 8));
        prog.push_back(addi(7, 0, 3));
        prog.push_back(jal(0, 0));
        expectRetire(1, immA);
        expectRetire(5, 32'd8);
        expectRetire(4, immA + 8);
        expectRetire(6, 32'd24);
        runAndCheck("jal");
    endtask

    initial begin
        #(testCount * cyclesPerTest * clkPeriodNs);
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        seed = 31446;
        reset = 1'b1;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        passCount = 0;
        failCount = 0;
        aluChainTest();
        zeroRegTest();
        loadUseTest();
        branchTest();
        jalTest();
        $display("%0d tests run, %0d passed, %0d failed",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/tbClock.sv
`timescale 1ns/1ps
module tbClock (
    output logic clk
);

    localparam int halfPeriodNs = 4;

    initial begin
        clk = 1'b0;
    end

    always begin
        #(halfPeriodNs) clk = ~clk;
    end

endmodule
